/* run.sh */
#!/usr/bin/env bash
# Build the register bank testbench with Verilator, run it and check the log.
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_axil_regbank -f sources.f -o tb_axil_regbank
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_axil_regbank > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** FAILED ***' "$log"; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"
exit 0

/* sim/axil_bridge_assert.sv */
`timescale 1ns/1ns

module axil_bridge_assert
(
	input logic         S_AXI_ACLK,
	input logic         S_AXI_ARESETN,
	input logic         S_AXI_AWREADY,
	input logic         S_AXI_WREADY,
	input logic [1:0]   S_AXI_BRESP,
	input logic         S_AXI_BVALID,
	input logic         S_AXI_BREADY,
	input logic         S_AXI_ARREADY,
	input logic [1:0]   S_AXI_RRESP,
	input logic         S_AXI_RVALID,
	input logic         S_AXI_RREADY,
	input logic         rf_wen
);

	ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_AWREADY == S_AXI_WREADY)
		else $error("AWREADY and WREADY differ");

	// the strobe lasts one cycle and the write response follows it.
	strobe_pulse: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rf_wen |=> !rf_wen && S_AXI_BVALID)
		else $error("rf_wen not a single pulse followed by BVALID");

	bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
		else $error("BVALID dropped before BREADY");

	rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID)
		else $error("RVALID dropped before RREADY");

	resp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(S_AXI_BVALID |-> S_AXI_BRESP == regbank_pkg::resp_okay) and
		(S_AXI_RVALID |-> S_AXI_RRESP == regbank_pkg::resp_okay))
		else $error("response is not OKAY");

	// handshake outputs come out of reset low.
	reset_low: assert property (@(posedge S_AXI_ACLK) !S_AXI_ARESETN |=>
		!(S_AXI_AWREADY || S_AXI_WREADY || S_AXI_BVALID || S_AXI_ARREADY || S_AXI_RVALID))
		else $error("handshake output high after reset");

endmodule

bind axi_lite_rf_bridge axil_bridge_assert bridge_assert_inst (.*);

/* sim/tb_axil_regbank.sv */
`timescale 1ns/1ns

module tb_axil_regbank;

	localparam int clk_period = 40;
	// reset reads, readback, slicing, out of range and back-pressure together.
	localparam int num_transactions = 152;
	localparam int timeout_cycles = num_transactions * 20 + 100;

	logic                                   S_AXI_ACLK;
	logic                                   S_AXI_ARESETN;
	logic [regbank_pkg::addr_width-1:0]     S_AXI_AWADDR;
	logic [2:0]                             S_AXI_AWPROT;
	logic                                   S_AXI_AWVALID;
	logic                                   S_AXI_AWREADY;
	logic [regbank_pkg::data_width-1:0]     S_AXI_WDATA;
	logic [regbank_pkg::strb_width-1:0]     S_AXI_WSTRB;
	logic                                   S_AXI_WVALID;
	logic                                   S_AXI_WREADY;
	logic [1:0]                             S_AXI_BRESP;
	logic                                   S_AXI_BVALID;
	logic                                   S_AXI_BREADY;
	logic [regbank_pkg::addr_width-1:0]     S_AXI_ARADDR;
	logic [2:0]                             S_AXI_ARPROT;
	logic                                   S_AXI_ARVALID;
	logic                                   S_AXI_ARREADY;
	logic [regbank_pkg::data_width-1:0]     S_AXI_RDATA;
	logic [1:0]                             S_AXI_RRESP;
	logic                                   S_AXI_RVALID;
	logic                                   S_AXI_RREADY;

	// expected contents of every implemented word.
	logic [regbank_pkg::data_width-1:0]     model [regbank_pkg::rf_depth];
	logic [31:0]                            seed;
	int                                     errors;
	int                                     checks;

	axil_regbank axil_regbank_inst (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever
		begin
			#(clk_period / 2) S_AXI_ACLK = ~S_AXI_ACLK;
		end
	end

	initial
	begin
		#(timeout_cycles * clk_period);
		$display("timeout: the tests did not complete within %0d cycles", timeout_cycles);
		$display("*** FAILED ***");
		$finish;
	end

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int random_word();
		return int'(next_random() % 32'(regbank_pkg::rf_depth));
	endfunction

	function automatic logic [31:0] byte_addr(input int word, input int offset);
		return 32'((word << regbank_pkg::addr_lsb) + offset);
	endfunction

	function automatic logic [31:0] resp_valid(input bit is_read);
		return is_read ? 32'(S_AXI_RVALID) : 32'(S_AXI_BVALID);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// entered at the falling edge where the response is first seen.
	task automatic accept_response(input string name, input bit is_read, input int hold,
		input logic [31:0] expected);
		for (int i = 0; i <= hold; i++)
		begin
			check_value({name, " valid held"}, 1, resp_valid(is_read));
			check_value({name, " resp"}, 32'(regbank_pkg::resp_okay),
				is_read ? 32'(S_AXI_RRESP) : 32'(S_AXI_BRESP));
			if (is_read)
			begin
				check_value({name, " rdata"}, expected, S_AXI_RDATA);
			end
			if (i < hold)
			begin
				@(negedge S_AXI_ACLK);
			end
		end
		if (hold > 0)
		begin
			@(posedge S_AXI_ACLK);
			if (is_read)
			begin
				S_AXI_RREADY <= 1'b1;
			end
			else
			begin
				S_AXI_BREADY <= 1'b1;
			end
			@(negedge S_AXI_ACLK);
			check_value({name, " valid at handshake"}, 1, resp_valid(is_read));
		end
		@(posedge S_AXI_ACLK);
		S_AXI_BREADY <= 1'b0;
		S_AXI_RREADY <= 1'b0;
		@(negedge S_AXI_ACLK);
		check_value({name, " single response"}, 0, resp_valid(is_read));
	endtask

	// readies show at the second falling edge after the drive edge, BVALID at the third.
	task automatic axi_write(input string name, input logic [31:0] addr,
		input logic [regbank_pkg::data_width-1:0] data, input int hold);
		int cycles;
		int ready_cycle;
		logic [31:0] side_bits;
		side_bits = next_random();
		@(posedge S_AXI_ACLK);
		S_AXI_AWADDR <= addr;
		S_AXI_AWPROT <= side_bits[6:4];
		S_AXI_WDATA <= data;
		S_AXI_WSTRB <= side_bits[3:0];
		S_AXI_AWVALID <= 1'b1;
		S_AXI_WVALID <= 1'b1;
		S_AXI_BREADY <= (hold == 0);
		cycles = 0;
		do
		begin
			@(negedge S_AXI_ACLK);
			cycles++;
		end
		while (!(S_AXI_AWREADY && S_AXI_WREADY));
		ready_cycle = cycles;
		@(posedge S_AXI_ACLK);
		S_AXI_AWVALID <= 1'b0;
		S_AXI_WVALID <= 1'b0;
		do
		begin
			@(negedge S_AXI_ACLK);
			cycles++;
		end
		while (!S_AXI_BVALID);
		check_value({name, " ready cycle"}, 2, ready_cycle);
		check_value({name, " bvalid cycle"}, 3, cycles);
		accept_response(name, 1'b0, hold, '0);
	endtask

	task automatic axi_read(input string name, input logic [31:0] addr,
		input logic [regbank_pkg::data_width-1:0] expected, input int hold);
		logic [31:0] side_bits;
		side_bits = next_random();
		@(posedge S_AXI_ACLK);
		S_AXI_ARADDR <= addr;
		S_AXI_ARPROT <= side_bits[2:0];
		S_AXI_ARVALID <= 1'b1;
		S_AXI_RREADY <= (hold == 0);
		do
			@(negedge S_AXI_ACLK);
		while (!S_AXI_ARREADY);
		@(posedge S_AXI_ACLK);
		S_AXI_ARVALID <= 1'b0;
		do
			@(negedge S_AXI_ACLK);
		while (!S_AXI_RVALID);
		accept_response(name, 1'b1, hold, expected);
	endtask

	task automatic test_reset_values();
		for (int i = 0; i < 8; i++)
		begin
			axi_read("reset_values", byte_addr(random_word(), 0), '0, 0);
		end
	endtask

	task automatic test_write_readback();
		int words [20];
		logic [regbank_pkg::data_width-1:0] data;
		for (int i = 0; i < 20; i++)
		begin
			words[i] = random_word();
			data = next_random();
			axi_write("write_readback", byte_addr(words[i], 0), data, 0);
			model[words[i]] = data;
		end
		for (int i = 0; i < 20; i++)
		begin
			axi_read("write_readback", byte_addr(words[i], 0), model[words[i]], 0);
		end
	endtask

	// byte offsets 0 to 3 all land on the same word.
	task automatic test_address_slicing();
		int word;
		logic [regbank_pkg::data_width-1:0] data;
		for (int i = 0; i < 4; i++)
		begin
			word = random_word();
			data = next_random();
			axi_write("address_slicing", byte_addr(word, i), data, 0);
			model[word] = data;
			for (int off = 0; off < 4; off++)
			begin
				axi_read("address_slicing", byte_addr(word, off), model[word], 0);
			end
		end
	endtask

	task automatic test_out_of_range();
		int word;
		for (int i = 0; i < 4; i++)
		begin
			word = regbank_pkg::rf_depth + int'(next_random() %
				32'((1 << regbank_pkg::rf_addr_bits) - regbank_pkg::rf_depth));
			axi_write("out_of_range", byte_addr(word, 0), next_random(), 0);
			axi_read("out_of_range", byte_addr(word, 0), '0, 0);
		end
		for (int w = 0; w < regbank_pkg::rf_depth; w++)
		begin
			axi_read("out_of_range", byte_addr(w, 0), model[w], 0);
		end
	endtask

	task automatic test_back_pressure();
		int word;
		logic [regbank_pkg::data_width-1:0] data;
		for (int i = 0; i < 6; i++)
		begin
			word = random_word();
			data = next_random();
			axi_write("back_pressure", byte_addr(word, 0), data, 1 + int'(next_random() % 32'd8));
			model[word] = data;
			axi_read("back_pressure", byte_addr(word, 0), model[word],
				1 + int'(next_random() % 32'd8));
		end
	endtask

	initial
	begin
		seed = 32'hb03f;
		errors = 0;
		checks = 0;
		for (int w = 0; w < regbank_pkg::rf_depth; w++)
		begin
			model[w] = '0;
		end
		S_AXI_ARESETN <= 1'b0;
		S_AXI_AWADDR <= '0;
		S_AXI_AWPROT <= '0;
		S_AXI_AWVALID <= 1'b0;
		S_AXI_WDATA <= '0;
		S_AXI_WSTRB <= '0;
		S_AXI_WVALID <= 1'b0;
		S_AXI_BREADY <= 1'b0;
		S_AXI_ARADDR <= '0;
		S_AXI_ARPROT <= '0;
		S_AXI_ARVALID <= 1'b0;
		S_AXI_RREADY <= 1'b0;
		repeat (3) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
		test_reset_values();
		test_write_readback();
		test_address_slicing();
		test_out_of_range();
		test_back_pressure();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("*** PASSED ***");
		end
		else
		begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* sources.f */
src/regbank_pkg.sv
src/axi_lite_rf_bridge.sv
src/reg_file.sv
src/axil_regbank.sv
sim/axil_bridge_assert.sv
sim/tb_axil_regbank.sv

/* src/axi_lite_rf_bridge.sv */
`timescale 1ns/1ns

module axi_lite_rf_bridge
(
	input  logic                                   S_AXI_ACLK,
	input  logic                                   S_AXI_ARESETN,

	input  logic [regbank_pkg::addr_width-1:0]     S_AXI_AWADDR,
	input  logic [2:0]                             S_AXI_AWPROT,
	input  logic                                   S_AXI_AWVALID,
	output logic                                   S_AXI_AWREADY,

	input  logic [regbank_pkg::data_width-1:0]     S_AXI_WDATA,
	input  logic [regbank_pkg::strb_width-1:0]     S_AXI_WSTRB,
	input  logic                                   S_AXI_WVALID,
	output logic                                   S_AXI_WREADY,

	output logic [1:0]                             S_AXI_BRESP,
	output logic                                   S_AXI_BVALID,
	input  logic                                   S_AXI_BREADY,

	input  logic [regbank_pkg::addr_width-1:0]     S_AXI_ARADDR,
	input  logic [2:0]                             S_AXI_ARPROT,
	input  logic                                   S_AXI_ARVALID,
	output logic                                   S_AXI_ARREADY,

	output logic [regbank_pkg::data_width-1:0]     S_AXI_RDATA,
	output logic [1:0]                             S_AXI_RRESP,
	output logic                                   S_AXI_RVALID,
	input  logic                                   S_AXI_RREADY,

	output logic [regbank_pkg::rf_addr_bits-1:0]   rf_waddr,
	output logic                                   rf_wen,
	output logic [regbank_pkg::data_width-1:0]     rf_wdata,
	output logic [regbank_pkg::rf_addr_bits-1:0]   rf_raddr,
	input  logic [regbank_pkg::data_width-1:0]     rf_rdata
);

	logic                                   aw_ready;
	logic                                   w_ready;
	logic                                   b_valid;
	logic [regbank_pkg::rf_addr_bits-1:0]   aw_word;

	logic                                   ar_ready;
	logic                                   r_valid;
	logic [regbank_pkg::data_width-1:0]     r_data;
	logic [regbank_pkg::rf_addr_bits-1:0]   ar_word;

	logic                                   wr_start;
	logic                                   rd_start;
	logic                                   rd_capture;

	// a write starts only once address and data are both offered.
	assign wr_start = !aw_ready && S_AXI_AWVALID && S_AXI_WVALID;

	// one read in flight, the address is taken when the last ready pulse is gone.
	assign rd_start = !ar_ready && S_AXI_ARVALID;

	assign S_AXI_AWREADY = aw_ready;
	assign S_AXI_WREADY  = w_ready;
	assign S_AXI_BVALID  = b_valid;
	assign S_AXI_BRESP   = regbank_pkg::resp_okay;

	assign S_AXI_ARREADY = ar_ready;
	assign S_AXI_RVALID  = r_valid;
	assign S_AXI_RDATA   = r_data;
	assign S_AXI_RRESP   = regbank_pkg::resp_okay;

	// address ready pulses for one cycle per accepted write.
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			aw_ready <= 1'b0;
		end
		else if (wr_start)
		begin
			aw_ready <= 1'b1;
		end
		else
		begin
			aw_ready <= 1'b0;
		end
	end

	// data ready follows the same rule, so both readies rise together.
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			w_ready <= 1'b0;
		end
		else if (!w_ready && S_AXI_WVALID && S_AXI_AWVALID)
		begin
			w_ready <= 1'b1;
		end
		else
		begin
			w_ready <= 1'b0;
		end
	end

	// keep only the word address bits.
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr_start)
		begin
			aw_word <= S_AXI_AWADDR[regbank_pkg::addr_lsb +: regbank_pkg::rf_addr_bits];
		end
	end

	// strobe during the ready cycle, data comes straight from the W channel.
	assign rf_wen   = aw_ready && S_AXI_AWVALID && w_ready && S_AXI_WVALID;
	assign rf_waddr = aw_word;
	assign rf_wdata = S_AXI_WDATA;

	// write response is raised after the strobe and held until taken.
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			b_valid <= 1'b0;
		end
		else if (rf_wen && !b_valid)
		begin
			b_valid <= 1'b1;
		end
		else if (b_valid && S_AXI_BREADY)
		begin
			b_valid <= 1'b0;
		end
	end

	// read address ready, one pulse per read.
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			ar_ready <= 1'b0;
		end
		else if (rd_start)
		begin
			ar_ready <= 1'b1;
		end
		else
		begin
			ar_ready <= 1'b0;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_start)
		begin
			ar_word <= S_AXI_ARADDR[regbank_pkg::addr_lsb +: regbank_pkg::rf_addr_bits];
		end
	end

	assign rf_raddr = ar_word;

	// register file answers combinationally while ARREADY is high.
	assign rd_capture = ar_ready && S_AXI_ARVALID && !r_valid;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_valid <= 1'b0;
		end
		else if (rd_capture)
		begin
			r_valid <= 1'b1;
		end
		else if (r_valid && S_AXI_RREADY)
		begin
			r_valid <= 1'b0;
		end
	end

	// read data holds until the next capture.
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_capture)
		begin
			r_data <= rf_rdata;
		end
	end

endmodule

/* src/axil_regbank.sv */
`timescale 1ns/1ns

module axil_regbank
(
	input  logic                                   S_AXI_ACLK,
	input  logic                                   S_AXI_ARESETN,

	input  logic [regbank_pkg::addr_width-1:0]     S_AXI_AWADDR,
	input  logic [2:0]                             S_AXI_AWPROT,
	input  logic                                   S_AXI_AWVALID,
	output logic                                   S_AXI_AWREADY,

	input  logic [regbank_pkg::data_width-1:0]     S_AXI_WDATA,
	input  logic [regbank_pkg::strb_width-1:0]     S_AXI_WSTRB,
	input  logic                                   S_AXI_WVALID,
	output logic                                   S_AXI_WREADY,

	output logic [1:0]                             S_AXI_BRESP,
	output logic                                   S_AXI_BVALID,
	input  logic                                   S_AXI_BREADY,

	input  logic [regbank_pkg::addr_width-1:0]     S_AXI_ARADDR,
	input  logic [2:0]                             S_AXI_ARPROT,
	input  logic                                   S_AXI_ARVALID,
	output logic                                   S_AXI_ARREADY,

	output logic [regbank_pkg::data_width-1:0]     S_AXI_RDATA,
	output logic [1:0]                             S_AXI_RRESP,
	output logic                                   S_AXI_RVALID,
	input  logic                                   S_AXI_RREADY
);

	// strobes between the bridge and the storage.
	logic [regbank_pkg::rf_addr_bits-1:0]   rf_waddr;
	logic                                   rf_wen;
	logic [regbank_pkg::data_width-1:0]     rf_wdata;
	logic [regbank_pkg::rf_addr_bits-1:0]   rf_raddr;
	logic [regbank_pkg::data_width-1:0]     rf_rdata;

	axi_lite_rf_bridge bridge_inst
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR  (S_AXI_AWADDR),
		.S_AXI_AWPROT  (S_AXI_AWPROT),
		.S_AXI_AWVALID (S_AXI_AWVALID),
		.S_AXI_AWREADY (S_AXI_AWREADY),
		.S_AXI_WDATA   (S_AXI_WDATA),
		.S_AXI_WSTRB   (S_AXI_WSTRB),
		.S_AXI_WVALID  (S_AXI_WVALID),
		.S_AXI_WREADY  (S_AXI_WREADY),
		.S_AXI_BRESP   (S_AXI_BRESP),
		.S_AXI_BVALID  (S_AXI_BVALID),
		.S_AXI_BREADY  (S_AXI_BREADY),
		.S_AXI_ARADDR  (S_AXI_ARADDR),
		.S_AXI_ARPROT  (S_AXI_ARPROT),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.S_AXI_RDATA   (S_AXI_RDATA),
		.S_AXI_RRESP   (S_AXI_RRESP),
		.S_AXI_RVALID  (S_AXI_RVALID),
		.S_AXI_RREADY  (S_AXI_RREADY),
		.rf_waddr      (rf_waddr),
		.rf_wen        (rf_wen),
		.rf_wdata      (rf_wdata),
		.rf_raddr      (rf_raddr),
		.rf_rdata      (rf_rdata)
	);

	reg_file reg_file_inst
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.rf_wen        (rf_wen),
		.rf_waddr      (rf_waddr),
		.rf_wdata      (rf_wdata),
		.rf_raddr      (rf_raddr),
		.rf_rdata      (rf_rdata)
	);

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ns

module reg_file
(
	input  logic                                   S_AXI_ACLK,
	input  logic                                   S_AXI_ARESETN,
	input  logic                                   rf_wen,
	input  logic [regbank_pkg::rf_addr_bits-1:0]   rf_waddr,
	input  logic [regbank_pkg::data_width-1:0]     rf_wdata,
	input  logic [regbank_pkg::rf_addr_bits-1:0]   rf_raddr,
	output logic [regbank_pkg::data_width-1:0]     rf_rdata
);

	logic [regbank_pkg::data_width-1:0]           mem [regbank_pkg::rf_depth];

	logic [$clog2(regbank_pkg::rf_depth)-1:0]     w_index;
	logic [$clog2(regbank_pkg::rf_depth)-1:0]     r_index;
	logic                                         w_in_range;
	logic                                         r_in_range;

	// the word address is much wider than the storage.
	assign w_in_range = rf_waddr < regbank_pkg::rf_addr_bits'(regbank_pkg::rf_depth);
	assign r_in_range = rf_raddr < regbank_pkg::rf_addr_bits'(regbank_pkg::rf_depth);

	assign w_index = rf_waddr[$clog2(regbank_pkg::rf_depth)-1:0];
	assign r_index = rf_raddr[$clog2(regbank_pkg::rf_depth)-1:0];

	// words start out as zero after reset.
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			for (int i = 0; i < regbank_pkg::rf_depth; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (rf_wen && w_in_range)
		begin
			mem[w_index] <= rf_wdata;
		end
	end

	// unimplemented words read back as zero.
	always_comb
	begin
		if (r_in_range)
		begin
			rf_rdata = mem[r_index];
		end
		else
		begin
			rf_rdata = '0;
		end
	end

endmodule

/* src/regbank_pkg.sv */
package regbank_pkg;

	// AXI4-Lite bus widths.
	localparam int addr_width = 32;
	localparam int data_width = 32;
	localparam int strb_width = data_width / 8;

	// lowest byte address bit that selects a word.
	localparam int addr_lsb = 2;

	// word address carried to the register file, byte address bits 2 to 18.
	localparam int rf_addr_bits = 17;

	// number of words actually implemented.
	localparam int rf_depth = 64;

	// only response this slave ever gives.
	localparam logic [1:0] resp_okay = 2'b00;

endpackage
